//--- all.f
+incdir+hdl
hdl/frame_pkg.sv
hdl/status_pkg.sv
hdl/pattern_gen.sv
hdl/lane_tx.sv
hdl/lane_rx.sv
hdl/pattern_check.sv
hdl/link_node.sv
sim/tb_clock.sv
sim/link_tb.sv

//--- Makefile
TOP = link_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f $(wildcard hdl/*) $(wildcard sim/*)
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

# The log decides the verdict, a fatal stop leaves no pass line
run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/link_tb.sv
`timescale 1ns/1ps
`include "link_consts.svh"

module link_tb import status_pkg::*; ();

  localparam int TIMEOUT  = 2000;
  // Flipped frame bit sits in slot 3 at data bit 5
  localparam int FLIP_POS = 3 * `WORD_W + 2;

  logic              clk;
  logic              por;
  logic              reset;
  logic              reset_req;
  logic [`LANES-1:0] rxp;
  logic [`LANES-1:0] txp;
  logic [7:0]        led;
  logic [`LANES-1:0] kill_mask;
  logic [`LANES-1:0] flip_req;
  logic [63:0]       dline [`LANES];
  int                skew [`LANES];
  int                tx_pos;
  logic [31:0]       rng_state;
  int                err_lane;

  tb_clock u_clk (
    .clk_o   (clk),
    .reset_o (por)
  );

  assign reset = por | reset_req;

  link_node DUT (
    .board_clk_i (clk),
    .reset_i     (reset),
    .rxp_i       (rxp),
    .txp_o       (txp),
    .led_o       (led)
  );

  // Loopback lines with per-lane skew driven 2 ns after the edge
  always @(posedge clk) begin
    logic              rst_seen;
    logic [`LANES-1:0] kill_seen;
    logic [`LANES-1:0] flip_seen;
    logic              bit_v;
    int                rx_pos;
    rst_seen  = reset;
    kill_seen = kill_mask;
    flip_seen = flip_req;
    #2;
    // Frame bit now on txp counted from the first sync MSB
    if (rst_seen) begin
      tx_pos = -1;
    end else if (tx_pos >= 0) begin
      tx_pos = (tx_pos + 1) % `FRAME_BITS;
    end else if (txp[0]) begin
      tx_pos = 0;
    end
    for (int l = 0; l < `LANES; l++) begin
      bit_v    = (skew[l] == 0) ? txp[l] : dline[l][skew[l]-1];
      dline[l] = {dline[l][62:0], txp[l]};
      rx_pos   = (tx_pos - skew[l] + `FRAME_BITS) % `FRAME_BITS;
      if (flip_seen[l] && tx_pos >= 0 && rx_pos == FLIP_POS) begin
        bit_v       = ~bit_v;
        flip_req[l] = 1'b0;
      end
      if (kill_seen[l]) begin
        bit_v = 1'b0;
      end
      rxp[l] = bit_v;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned pick_below(input int unsigned range);
    rng_state = xorshift32(rng_state);
    return rng_state % range;
  endfunction

  // LED image of a clean link with every lane locked
  function automatic logic [7:0] locked_led();
    logic [7:0] v;
    v = '0;
    for (int l = 0; l < `LANES; l++) begin
      v[LOCK0 + l] = 1'b1;
    end
    v[ALL_LOCKED] = 1'b1;
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_led(input logic [7:0] exp, input logic [7:0] mask, input string ctx);
    if ((led & mask) !== (exp & mask)) begin
      abort_run($sformatf("Fail led_o (%s): got %h expected %h under mask %h",
                          ctx, led, exp, mask));
    end
  endtask

  task automatic check_txp(input logic [`LANES-1:0] exp, input string ctx);
    if (txp !== exp) begin
      abort_run($sformatf("Fail txp_o (%s): got %h expected %h", ctx, txp, exp));
    end
  endtask

  task automatic check_tx_word(input int lane, input int idx,
                               input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail txp_o[%0d] word %0d: got %h expected %h",
                          lane, idx, got, exp));
    end
  endtask

  task automatic wait_led(input led_pos_e pos, input logic val, input string what);
    int n;
    n = 0;
    while (led[pos] !== val) begin
      if (n >= TIMEOUT) begin
        abort_run($sformatf("Timeout after %0d cycles waiting for %s", TIMEOUT, what));
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_flip_done(input int lane);
    int n;
    n = 0;
    @(posedge clk);
    while (flip_req[lane]) begin
      if (n >= TIMEOUT) begin
        abort_run($sformatf("Timeout: bit flip on lane %0d never happened", lane));
      end
      @(posedge clk);
      n++;
    end
  endtask

  task automatic hold_and_check(input int cycles, input logic [7:0] exp,
                                input logic [7:0] mask, input string ctx);
    repeat (cycles) begin
      @(negedge clk);
      check_led(exp, mask, ctx);
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #2 reset_req = 1'b1;
    repeat (8) @(posedge clk);
    #2 reset_req = 1'b0;
  endtask

  task automatic test_reset_state();
    int n;
    n = 0;
    @(negedge clk);
    while (reset) begin
      if (n >= TIMEOUT) begin
        abort_run("Timeout: power-on reset never released");
      end
      check_led(8'h00, 8'hFF, "in reset");
      check_txp('0, "in reset");
      @(negedge clk);
      n++;
    end
    // First cycle out of reset with nothing loaded yet
    @(negedge clk);
    check_led(8'h00, 8'hFF, "after reset");
    check_txp('0, "after reset");
  endtask

  task automatic test_tx_pattern();
    int                             n;
    int                             slot;
    int                             data_idx;
    logic [`LANES-1:0][`WORD_W-1:0] got;
    logic [`WORD_W-1:0]             exp;
    n = 0;
    @(negedge clk);
    while (tx_pos != 0) begin
      if (n >= TIMEOUT) begin
        abort_run("Timeout: first word never appeared on txp_o");
      end
      @(negedge clk);
      n++;
    end
    for (int w = 0; w < 3 * `FRAME_WORDS; w++) begin
      got = '0;
      for (int b = 0; b < `WORD_W; b++) begin
        for (int l = 0; l < `LANES; l++) begin
          got[l] = {got[l][`WORD_W-2:0], txp[l]};
        end
        @(negedge clk);
      end
      slot = w % `FRAME_WORDS;
      for (int l = 0; l < `LANES; l++) begin
        if (slot == 0) begin
          exp = `SYNC_WORD;
        end else begin
          // Lane counter starts at the lane index and steps once per data slot
          data_idx = (w / `FRAME_WORDS) * (`FRAME_WORDS - 1) + slot - 1;
          exp      = 8'((l + data_idx) % (1 << `DATA_W));
        end
        check_tx_word(l, w, got[l], exp);
      end
    end
  endtask

  task automatic wait_all_locked();
    for (int l = 0; l < `LANES; l++) begin
      wait_led(led_pos_e'(LOCK0 + l), 1'b1, $sformatf("lock of lane %0d", l));
    end
    wait_led(ALL_LOCKED, 1'b1, "all lanes locked");
  endtask

  task automatic test_lock_default();
    wait_all_locked();
    hold_and_check(20 * `FRAME_BITS, locked_led(), 8'hFF, "default skews");
  endtask

  task automatic test_random_retrain();
    @(posedge clk);
    for (int l = 0; l < `LANES; l++) begin
      skew[l] = pick_below(41);
    end
    $display("Retrain with skews %0d %0d %0d", skew[0], skew[1], skew[2]);
    reset_dut();
    wait_all_locked();
    hold_and_check(4 * `FRAME_BITS, locked_led(), 8'hFF, "random skews");
  endtask

  task automatic test_bit_error(output int lane);
    logic [7:0] exp;
    lane = pick_below(`LANES);
    repeat (pick_below(200)) @(posedge clk);
    $display("Flipping one data bit on lane %0d", lane);
    @(posedge clk);
    #2 flip_req[lane] = 1'b1;
    wait_flip_done(lane);
    wait_led(led_pos_e'(ERR0 + lane), 1'b1, "error LED of the corrupted lane");
    exp            = locked_led();
    exp[ERR0+lane] = 1'b1;
    exp[ANY_ERR]   = 1'b1;
    hold_and_check(4 * `FRAME_BITS, exp, 8'hFF, "after bit error");
  endtask

  task automatic test_lane_loss(input int bad_lane);
    int         k;
    logic [7:0] exp;
    logic [7:0] mask;
    k = pick_below(`LANES);
    $display("Holding lane %0d low", k);
    @(posedge clk);
    #2 kill_mask[k] = 1'b1;
    wait_led(led_pos_e'(LOCK0 + k), 1'b0, "lock loss on the dead lane");
    wait_led(ALL_LOCKED, 1'b0, "all-locked to drop");
    // Error bits stay out of the mask as the dead lane delivers zero words before it drops
    mask = 8'h00;
    exp  = 8'h00;
    for (int l = 0; l < `LANES; l++) begin
      mask[LOCK0+l] = 1'b1;
      exp[LOCK0+l]  = (l != k);
    end
    mask[ALL_LOCKED] = 1'b1;
    hold_and_check(2 * `FRAME_BITS, exp, mask, "lane held low");
    @(posedge clk);
    #2 kill_mask[k] = 1'b0;
    wait_all_locked();
    // Error latch of the corrupted lane holds until reset
    mask               = 8'h00;
    mask[ERR0+bad_lane] = 1'b1;
    mask[ANY_ERR]      = 1'b1;
    check_led(mask, mask, "error latched before final reset");
    reset_dut();
    @(negedge clk);
    check_led(8'h00, 8'hFF, "final reset");
    wait_all_locked();
    hold_and_check(4 * `FRAME_BITS, locked_led(), 8'hFF, "after final reset");
  endtask

  initial begin
    rng_state = 32'hb4417b1b;
    reset_req = 1'b0;
    kill_mask = '0;
    flip_req  = '0;
    rxp       = '0;
    tx_pos    = -1;
    skew[0]   = 0;
    skew[1]   = 3;
    skew[2]   = 11;
    for (int l = 0; l < `LANES; l++) begin
      dline[l] = '0;
    end
    test_reset_state();
    test_tx_pattern();
    test_lock_default();
    test_random_retrain();
    test_bit_error(err_lane);
    test_lane_loss(err_lane);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  // 20 ns board clock
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Power-on reset for 8 cycles, released just after an edge
  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

//--- hdl/link_node.sv
`timescale 1ns/1ps
`include "link_consts.svh"

module link_node import status_pkg::*; (
  input  logic              board_clk_i,
  input  logic              reset_i,
  input  logic [`LANES-1:0] rxp_i,
  output logic [`LANES-1:0] txp_o,
  output logic [7:0]        led_o
);

  logic [`LANES-1:0][`WORD_W-1:0] tx_word;
  logic                           word_stb;
  logic [`LANES-1:0][`WORD_W-1:0] rx_word;
  logic [`LANES-1:0]              rx_stb;
  logic [`LANES-1:0]              rx_sof;
  lane_state_e [`LANES-1:0]       lane_state;

  // One shared word clock drives all lanes in step
  pattern_gen u_gen (
    .board_clk_i (board_clk_i),
    .reset_i     (reset_i),
    .tx_word_o   (tx_word),
    .word_stb_o  (word_stb)
  );

  genvar l;
  generate
    for (l = 0; l < `LANES; l++) begin : g_lane
      lane_tx u_tx (
        .board_clk_i (board_clk_i),
        .reset_i     (reset_i),
        .word_i      (tx_word[l]),
        .word_stb_i  (word_stb),
        .txp_o       (txp_o[l])
      );

      // Each receiver aligns on its own, lanes may arrive with any skew
      lane_rx u_rx (
        .board_clk_i  (board_clk_i),
        .reset_i      (reset_i),
        .rxp_i        (rxp_i[l]),
        .rx_word_o    (rx_word[l]),
        .rx_stb_o     (rx_stb[l]),
        .rx_sof_o     (rx_sof[l]),
        .lane_state_o (lane_state[l])
      );
    end
  endgenerate

  pattern_check u_check (
    .board_clk_i  (board_clk_i),
    .reset_i      (reset_i),
    .rx_word_i    (rx_word),
    .rx_stb_i     (rx_stb),
    .rx_sof_i     (rx_sof),
    .lane_state_i (lane_state),
    .led_o        (led_o)
  );

endmodule

//--- hdl/pattern_check.sv
`timescale 1ns/1ps
`include "link_consts.svh"

module pattern_check import frame_pkg::*, status_pkg::*; (
  input  logic                           board_clk_i,
  input  logic                           reset_i,
  input  logic [`LANES-1:0][`WORD_W-1:0] rx_word_i,
  input  logic [`LANES-1:0]              rx_stb_i,
  input  logic [`LANES-1:0]              rx_sof_i,
  input  lane_state_e [`LANES-1:0]       lane_state_i,
  output logic [7:0]                     led_o
);

  localparam int DW = `DATA_W;

  logic [`LANES-1:0][DW-1:0] expect_q;
  logic [`LANES-1:0]         seeded;
  logic [`LANES-1:0]         err_q;
  logic [`LANES-1:0]         lock_q;
  logic                      all_locked_q;
  logic                      any_err_q;
  logic [`LANES-1:0]         locked;
  logic [`LANES-1:0]         data_vld;
  logic [`LANES-1:0]         bad;
  word_kind_e [`LANES-1:0]   kind;

  always_comb begin
    for (int l = 0; l < `LANES; l++) begin
      locked[l]   = (lane_state_i[l] == LS_LOCKED);
      kind[l]     = rx_sof_i[l] ? WK_SYNC : WK_DATA;
      data_vld[l] = rx_stb_i[l] && locked[l] && (kind[l] == WK_DATA);
      // Top bit must be clear, low bits must follow the count once seeded
      bad[l]      = data_vld[l] &&
                    (rx_word_i[l][`WORD_W-1] ||
                     (seeded[l] && rx_word_i[l][DW-1:0] != expect_q[l]));
    end
  end

  always_ff @(posedge board_clk_i) begin
    if (reset_i) begin
      seeded       <= '0;
      err_q        <= '0;
      lock_q       <= '0;
      all_locked_q <= 1'b0;
      any_err_q    <= 1'b0;
    end else begin
      for (int l = 0; l < `LANES; l++) begin
        if (!locked[l]) begin
          seeded[l] <= 1'b0;
        end else if (data_vld[l]) begin
          seeded[l] <= 1'b1;
        end
      end
      err_q        <= err_q | bad;
      any_err_q    <= |(err_q | bad);
      lock_q       <= locked;
      all_locked_q <= &locked;
    end
  end

  // Expected count, seeded from the first data word and stepped on each one after
  always_ff @(posedge board_clk_i) begin
    for (int l = 0; l < `LANES; l++) begin
      if (data_vld[l]) begin
        expect_q[l] <= seeded[l] ? expect_q[l] + 1'b1 : rx_word_i[l][DW-1:0] + 1'b1;
      end
    end
  end

  always_comb begin
    led_o = '0;
    for (int l = 0; l < `LANES; l++) begin
      led_o[LOCK0 + l] = lock_q[l];
      led_o[ERR0 + l]  = err_q[l];
    end
    led_o[ALL_LOCKED] = all_locked_q;
    led_o[ANY_ERR]    = any_err_q;
  end

endmodule

//--- hdl/lane_rx.sv
`timescale 1ns/1ps
`include "link_consts.svh"

module lane_rx import frame_pkg::*, status_pkg::*; (
  input  logic               board_clk_i,
  input  logic               reset_i,
  input  logic               rxp_i,
  output logic [`WORD_W-1:0] rx_word_o,
  output logic               rx_stb_o,
  output logic               rx_sof_o,
  output lane_state_e        lane_state_o
);

  localparam int PW = $clog2(`FRAME_BITS);
  localparam int BW = $clog2(`WORD_W);
  localparam int HW = $clog2(`LOCK_SYNCS + 1);
  localparam int MW = $clog2(`LOSS_MISSES + 1);

  localparam logic [HW-1:0] HITS_LAST = HW'(`LOCK_SYNCS - 1);
  localparam logic [MW-1:0] MISS_LAST = MW'(`LOSS_MISSES - 1);

  logic [`WORD_W-1:0] win;
  logic [PW-1:0]      pos;
  logic [HW-1:0]      hits;
  logic [MW-1:0]      misses;
  logic               hit;
  logic               word_bnd;
  logic               frame_bnd;
  word_kind_e         win_kind;
  lane_state_e        state;
  lane_state_e        state_n;

  // Sliding window, newest bit in the LSB
  always_ff @(posedge board_clk_i) begin
    if (reset_i) begin
      win <= '0;
    end else begin
      win <= {win[`WORD_W-2:0], rxp_i};
    end
  end

  assign win_kind  = (win == `SYNC_WORD) ? WK_SYNC : WK_DATA;
  assign hit       = (win_kind == WK_SYNC);

  // pos counts bits since the last expected sync, 0 means window holds slot 0
  assign word_bnd  = (pos[BW-1:0] == '0);
  assign frame_bnd = (pos == '0);

  always_comb begin
    state_n = state;
    unique case (state)
      LS_HUNT: begin
        if (hit) begin
          state_n = LS_VERIFY;
        end
      end
      LS_VERIFY: begin
        if (frame_bnd) begin
          if (!hit) begin
            state_n = LS_HUNT;
          end else if (hits == HITS_LAST) begin
            state_n = LS_LOCKED;
          end
        end
      end
      LS_LOCKED: begin
        if (frame_bnd && !hit && misses == MISS_LAST) begin
          state_n = LS_HUNT;
        end
      end
      default: state_n = LS_HUNT;
    endcase
  end

  always_ff @(posedge board_clk_i) begin
    if (reset_i) begin
      state  <= LS_HUNT;
      pos    <= '0;
      hits   <= '0;
      misses <= '0;
    end else begin
      state <= state_n;

      // Realign the bit position on a hunting hit
      if (state == LS_HUNT && hit) begin
        pos <= PW'(1);
      end else begin
        pos <= pos + 1'b1;
      end

      // Consecutive syncs seen at the captured offset
      unique case (state)
        LS_HUNT:   hits <= hit ? HW'(1) : '0;
        LS_VERIFY: begin
          if (frame_bnd) begin
            hits <= hit ? hits + 1'b1 : '0;
          end
        end
        default:   hits <= '0;
      endcase

      // Consecutive missing syncs while locked
      if (state != LS_LOCKED) begin
        misses <= '0;
      end else if (frame_bnd) begin
        misses <= hit ? '0 : misses + 1'b1;
      end
    end
  end

  // Word output on boundaries, strobes follow the next state
  always_ff @(posedge board_clk_i) begin
    if (reset_i) begin
      rx_stb_o <= 1'b0;
      rx_sof_o <= 1'b0;
    end else begin
      rx_stb_o <= (state_n == LS_LOCKED) && word_bnd;
      rx_sof_o <= (state_n == LS_LOCKED) && frame_bnd && hit;
    end
  end

  always_ff @(posedge board_clk_i) begin
    rx_word_o <= win;
  end

  assign lane_state_o = state;

  a_stb_locked: assert property (
    @(posedge board_clk_i) disable iff (reset_i)
      rx_stb_o |-> (lane_state_o == LS_LOCKED)
  );

  a_sof_is_sync: assert property (
    @(posedge board_clk_i) disable iff (reset_i)
      rx_sof_o |-> (rx_stb_o && rx_word_o == `SYNC_WORD)
  );

endmodule

//--- hdl/lane_tx.sv
`timescale 1ns/1ps
`include "link_consts.svh"

module lane_tx (
  input  logic               board_clk_i,
  input  logic               reset_i,
  input  logic [`WORD_W-1:0] word_i,
  input  logic               word_stb_i,
  output logic               txp_o
);

  localparam int CW = $clog2(`WORD_W) + 1;

  logic [`WORD_W-1:0] sreg;
  logic [CW-1:0]      bits_left;

  // Load on strobe, otherwise shift towards the MSB with zero fill
  always_ff @(posedge board_clk_i) begin
    if (reset_i) begin
      sreg      <= '0;
      bits_left <= '0;
    end else if (word_stb_i) begin
      sreg      <= word_i;
      bits_left <= CW'(`WORD_W);
    end else begin
      sreg <= {sreg[`WORD_W-2:0], 1'b0};
      if (bits_left != '0) begin
        bits_left <= bits_left - 1'b1;
      end
    end
  end

  // MSB first on the line
  assign txp_o = sreg[`WORD_W-1];

  // Next load may only land while the last bit of the previous word is on the line
  a_no_overrun: assert property (
    @(posedge board_clk_i) disable iff (reset_i)
      word_stb_i |-> (bits_left <= CW'(1))
  );

endmodule

//--- hdl/pattern_gen.sv
`timescale 1ns/1ps
`include "link_consts.svh"

module pattern_gen import frame_pkg::*; (
  input  logic                               board_clk_i,
  input  logic                               reset_i,
  output logic [`LANES-1:0][`WORD_W-1:0]     tx_word_o,
  output logic                               word_stb_o
);

  localparam int BW = $clog2(`WORD_W);
  localparam int SW = $clog2(`FRAME_WORDS);
  localparam int DW = `DATA_W;

  logic [BW-1:0]                bit_cnt;
  logic [SW-1:0]                slot;
  logic [`LANES-1:0][DW-1:0]    cnt;
  logic                         word_end;
  word_kind_e                   kind;

  // Last bit period of the current word
  assign word_end = (bit_cnt == '1);

  // Slot 0 of every frame is the sync marker
  assign kind = (slot == '0) ? WK_SYNC : WK_DATA;

  always_ff @(posedge board_clk_i) begin
    if (reset_i) begin
      // Start one count early so the first strobe follows reset release
      bit_cnt    <= '1;
      slot       <= '0;
      word_stb_o <= 1'b0;
    end else begin
      bit_cnt    <= bit_cnt + 1'b1;
      word_stb_o <= word_end;
      if (word_end) begin
        slot <= slot + 1'b1;
      end
    end
  end

  // Lane counters and the word payload that goes out with the strobe
  always_ff @(posedge board_clk_i) begin
    if (reset_i) begin
      for (int l = 0; l < `LANES; l++) begin
        cnt[l] <= DW'(l);
      end
    end else if (word_end) begin
      for (int l = 0; l < `LANES; l++) begin
        if (kind == WK_SYNC) begin
          tx_word_o[l] <= `SYNC_WORD;
        end else begin
          tx_word_o[l] <= {1'b0, cnt[l]};
          cnt[l]       <= cnt[l] + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/status_pkg.sv
package status_pkg;

  // Receiver alignment state per lane
  typedef enum logic [1:0] {
    LS_HUNT,
    LS_VERIFY,
    LS_LOCKED
  } lane_state_e;

  // Bit positions on the eight-bit LED port
  typedef enum int unsigned {
    LOCK0      = 0,
    LOCK1      = 1,
    LOCK2      = 2,
    ERR0       = 3,
    ERR1       = 4,
    ERR2       = 5,
    ALL_LOCKED = 6,
    ANY_ERR    = 7
  } led_pos_e;

endpackage

//--- hdl/frame_pkg.sv
package frame_pkg;

  // What a frame slot carries
  // Slot 0 holds the sync word, slots 1 to 7 the counting pattern
  typedef enum logic {
    WK_SYNC,
    WK_DATA
  } word_kind_e;

endpackage

//--- hdl/link_consts.svh
`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// Lane count is tied to the LED map, three lock and three error bits
`define LANES 3

// Serial word and frame geometry
`define WORD_W 8
`define FRAME_WORDS 8
`define FRAME_BITS (`FRAME_WORDS * `WORD_W)

// Width of the per-lane counting pattern, top data bit is always zero
`define DATA_W 7

// Comma-like marker sent in slot 0 of every frame
`define SYNC_WORD 8'hBC

// Receiver lock thresholds, counted in frames
`define LOCK_SYNCS 3
`define LOSS_MISSES 2

`endif
